/* files.f */
logic/carPkg.sv
logic/trackSensor.sv
logic/phaseTimer.sv
logic/routeController.sv
logic/statusLeds.sv
logic/digitDisplay.sv
logic/motorDrive.sv
logic/lineCar.sv
verif/lineCarTb.sv

/* logic/carPkg.sv */
`default_nettype none

package carPkg;

    // Sensor bits are {left, mid, right}, 1 means on the line
    typedef enum logic [2:0] {
        errorRoad    = 3'b000,
        rightLittle  = 3'b001,
        straightRoad = 3'b010,
        rightRoad    = 3'b011,
        leftLittle   = 3'b100,
        turn101      = 3'b101,
        leftRoad     = 3'b110,
        turn111      = 3'b111
    } roadPattern;

    typedef enum logic [3:0] {
        stIdle,
        stStart,
        stCount,
        stStraight,
        stLittleLeft,
        stLittleRight,
        stChoose,
        stLeft,
        stRight,
        stBack,
        stStop,
        stError
    } carState;

    // Codes 0 to 9 are plain decimal digits
    typedef enum logic [3:0] {
        glyphSection = 4'd10,
        glyphBlank   = 4'd11,
        glyphI       = 4'd12,
        glyphD       = 4'd13,
        glyphL       = 4'd14,
        glyphError   = 4'd15
    } digitGlyph;

    // Segment order {g, f, e, d, c, b, a}, active low
    localparam logic [0:15][6:0] glyphSegments = {
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000,
        7'b0111111,  // section bar
        7'b1111111,  // blank
        7'b1001111,  // I
        7'b0100001,  // d
        7'b1000111,  // L
        7'b0000110   // E
    };

    typedef struct packed {
        digitGlyph d3;
        digitGlyph d2;
        digitGlyph d1;
        digitGlyph d0;
    } digitSet;

    typedef struct packed {
        logic forward;
        logic reverse;
        logic fast;
    } wheelCmd;

    typedef struct packed {
        wheelCmd left;
        wheelCmd right;
    } driveCmd;

    typedef struct packed {
        logic       countFinish;
        logic       pauseDone;
        logic       blink;
        logic [1:0] countPhase;
    } timerStatus;

endpackage

`default_nettype wire

/* logic/digitDisplay.sv */
`timescale 1ns/1ps
`default_nettype none

module digitDisplay #(
    parameter int scanCycles = 100_000
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              carPkg::carState state,
    input  wire              cpStraight,
    input  wire              cpChoose,
    input  wire              cpLeft,
    input  wire              cpRight,
    input  wire [1:0]        countPhase,
    output logic [3:0]       digit,
    output logic [6:0]       segments
);
    import carPkg::*;

    localparam int ScanW = $clog2(scanCycles + 1);

    logic [ScanW-1:0] scanCount;
    logic [1:0]       index;
    digitSet          glyphs;
    digitGlyph        shown;

    always_comb begin
        case (state)
            stIdle: glyphs = '{digitGlyph'(4'd1), glyphI, glyphD, glyphL};
            stStart: glyphs = '{4{glyphBlank}};
            stCount: glyphs = '{glyphBlank, glyphBlank, glyphBlank,
                                digitGlyph'(4'd3 - {2'b00, countPhase})};
            stStraight, stLittleLeft, stLittleRight:
                glyphs = '{glyphSection, digitGlyph'(4'd2), glyphBlank,
                           digitGlyph'({3'b000, cpStraight})};
            stChoose: glyphs = '{glyphSection, digitGlyph'(4'd1), glyphBlank,
                                 digitGlyph'({3'b000, cpChoose})};
            stLeft: glyphs = '{glyphSection, digitGlyph'(4'd3), glyphBlank,
                               digitGlyph'({3'b000, cpLeft})};
            stRight: glyphs = '{glyphSection, digitGlyph'(4'd4), glyphBlank,
                                digitGlyph'({3'b000, cpRight})};
            stBack, stStop: glyphs = '{4{digitGlyph'(4'd0)}};
            default: glyphs = '{4{glyphError}};
        endcase
    end

    // Digit scan
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanCount <= '0;
            index     <= 2'd0;
        end else if (scanCount == ScanW'(scanCycles - 1)) begin
            scanCount <= '0;
            index     <= index + 2'd1;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    always_comb begin
        case (index)
            2'd0: shown = glyphs.d0;
            2'd1: shown = glyphs.d1;
            2'd2: shown = glyphs.d2;
            default: shown = glyphs.d3;
        endcase
    end

    assign digit    = ~(4'b0001 << index);
    assign segments = glyphSegments[shown];

endmodule

`default_nettype wire

/* logic/lineCar.sv */
`timescale 1ns/1ps
`default_nettype none

module lineCar #(
    parameter int phaseCycles = 100_000_000,
    parameter int pauseCycles = 50_000_000,
    parameter int blinkCycles = 25_000_000,
    parameter int lampCycles  = 30_000_000,
    parameter int scanCycles  = 100_000,
    parameter int pwmPeriod   = 1024,
    parameter int slowDuty    = 512
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         run,
    input  wire         leftTrack,
    input  wire         midTrack,
    input  wire         rightTrack,
    output logic [15:0] led,
    output logic [3:0]  digit,
    output logic [6:0]  segments,
    output logic        in1,
    output logic        in2,
    output logic        in3,
    output logic        in4,
    output logic        pwmLeft,
    output logic        pwmRight
);
    import carPkg::*;

    roadPattern road;
    carState    state;
    timerStatus timers;
    logic       cpStraight;
    logic       cpChoose;
    logic       cpLeft;
    logic       cpRight;
    logic       countDone;
    logic [1:0] countPhase;
    logic       countBlink;
    logic       pauseDone;
    logic       backBlink;

    trackSensor u_trackSensor (
        .clk(clk), .rst(rst), .leftTrack(leftTrack), .midTrack(midTrack),
        .rightTrack(rightTrack), .road(road)
    );

    routeController u_routeController (
        .clk(clk), .rst(rst), .run(run), .road(road), .timers(timers),
        .state(state), .cpStraight(cpStraight), .cpChoose(cpChoose),
        .cpLeft(cpLeft), .cpRight(cpRight)
    );

    // Start countdown, stop pause and reversing blink
    phaseTimer #(.phaseCycles(phaseCycles), .phases(4)) u_countTimer (
        .clk(clk), .rst(rst), .enable(state == stCount),
        .done(countDone), .phase(countPhase), .blink(countBlink)
    );

    phaseTimer #(.phaseCycles(pauseCycles), .phases(1)) u_pauseTimer (
        .clk(clk), .rst(rst), .enable(state == stStop),
        .done(pauseDone), .phase(), .blink()
    );

    phaseTimer #(.phaseCycles(blinkCycles), .phases(1)) u_blinkTimer (
        .clk(clk), .rst(rst), .enable(state == stBack),
        .done(), .phase(), .blink(backBlink)
    );

    // Only one of the blink sources runs at a time
    assign timers = '{countFinish: countDone, pauseDone: pauseDone,
                      blink: countBlink | backBlink, countPhase: countPhase};

    statusLeds #(.lampCycles(lampCycles)) u_statusLeds (
        .clk(clk), .rst(rst), .state(state), .road(road), .timers(timers), .led(led)
    );

    digitDisplay #(.scanCycles(scanCycles)) u_digitDisplay (
        .clk(clk), .rst(rst), .state(state), .cpStraight(cpStraight),
        .cpChoose(cpChoose), .cpLeft(cpLeft), .cpRight(cpRight),
        .countPhase(timers.countPhase), .digit(digit), .segments(segments)
    );

    motorDrive #(.pwmPeriod(pwmPeriod), .slowDuty(slowDuty)) u_motorDrive (
        .clk(clk), .rst(rst), .state(state), .in1(in1), .in2(in2), .in3(in3),
        .in4(in4), .pwmLeft(pwmLeft), .pwmRight(pwmRight)
    );

endmodule

`default_nettype wire

/* logic/motorDrive.sv */
`timescale 1ns/1ps
`default_nettype none

module motorDrive #(
    parameter int pwmPeriod = 1024,
    parameter int slowDuty  = 512
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              carPkg::carState state,
    output logic             in1,
    output logic             in2,
    output logic             in3,
    output logic             in4,
    output logic             pwmLeft,
    output logic             pwmRight
);
    import carPkg::*;

    localparam int PwmW = $clog2(pwmPeriod + 1);

    // {forward, reverse, fast}
    localparam wheelCmd fwdFast = 3'b101;
    localparam wheelCmd fwdSlow = 3'b100;
    localparam wheelCmd revFast = 3'b011;
    localparam wheelCmd wheelOff = 3'b000;

    logic [PwmW-1:0] pwmCount;
    logic            slowOn;
    driveCmd         cmd;

    function automatic logic wheelPwm(input wheelCmd w, input logic slow);
        return (w.forward | w.reverse) & (w.fast | slow);
    endfunction

    always_comb begin
        case (state)
            stStraight: cmd = '{fwdFast, fwdFast};
            stLittleLeft: cmd = '{fwdSlow, fwdFast};
            stLittleRight: cmd = '{fwdFast, fwdSlow};
            stChoose: cmd = '{fwdSlow, fwdSlow};
            stLeft: cmd = '{revFast, fwdFast};
            stRight: cmd = '{fwdFast, revFast};
            stBack: cmd = '{revFast, revFast};
            default: cmd = '{wheelOff, wheelOff};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwmCount <= '0;
        end else if (pwmCount == PwmW'(pwmPeriod - 1)) begin
            pwmCount <= '0;
        end else begin
            pwmCount <= pwmCount + 1'b1;
        end
    end

    assign slowOn   = pwmCount < PwmW'(slowDuty);
    assign in1      = cmd.left.forward;
    assign in2      = cmd.left.reverse;
    assign in3      = cmd.right.forward;
    assign in4      = cmd.right.reverse;
    assign pwmLeft  = wheelPwm(cmd.left, slowOn);
    assign pwmRight = wheelPwm(cmd.right, slowOn);

endmodule

`default_nettype wire

/* logic/phaseTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module phaseTimer #(
    parameter int phaseCycles = 100_000_000,
    parameter int phases      = 4
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        enable,
    output logic       done,
    output logic [1:0] phase,
    output logic       blink
);
    localparam int CntW = $clog2(phaseCycles + 1);
    localparam logic [CntW-1:0] lastCount = CntW'(phaseCycles - 1);
    localparam logic [1:0] lastPhase = 2'(phases - 1);

    logic [CntW-1:0] count;
    logic            finished;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count    <= '0;
            phase    <= 2'd0;
            blink    <= 1'b0;
            done     <= 1'b0;
            finished <= 1'b0;
        end else if (!enable) begin
            count    <= '0;
            phase    <= 2'd0;
            blink    <= 1'b0;
            done     <= 1'b0;
            finished <= 1'b0;
        end else begin
            done <= 1'b0;
            if (count == lastCount) begin
                count <= '0;
                blink <= ~blink;
                // Phase holds on the last step, done fires once
                if (phase == lastPhase) begin
                    done     <= !finished;
                    finished <= 1'b1;
                end else begin
                    phase <= phase + 2'd1;
                end
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/routeController.sv */
`timescale 1ns/1ps
`default_nettype none

module routeController (
    input  wire                carPkg::roadPattern road,
    input  wire                carPkg::timerStatus timers,
    input  wire                clk,
    input  wire                rst,
    input  wire                run,
    output carPkg::carState    state,
    output logic               cpStraight,
    output logic               cpChoose,
    output logic               cpLeft,
    output logic               cpRight
);
    import carPkg::*;

    carState    nextState;
    carState    resume;
    carState    nextResume;
    logic [1:0] rightCount;
    logic       rightConfirmed;
    logic       straightSeen;
    logic       inStraight;

    assign inStraight = (state == stStraight) || (state == stLittleLeft) ||
                        (state == stLittleRight);

    always_comb begin
        nextState  = state;
        nextResume = resume;
        case (state)
            stIdle: if (run) nextState = stStart;
            stStart: if (road == straightRoad) nextState = stCount;
            stCount: if (timers.countFinish) nextState = stStraight;
            stStraight, stLittleLeft, stLittleRight: begin
                case (road)
                    errorRoad: begin
                        nextState  = stStop;
                        nextResume = stBack;
                    end
                    turn111: nextState = cpStraight ? stChoose : stStraight;
                    rightLittle: nextState = stLittleRight;
                    leftLittle: nextState = stLittleLeft;
                    default: nextState = stStraight;
                endcase
            end
            stChoose: begin
                if (road == turn101) begin
                    nextState  = stStop;
                    nextResume = stLeft;
                end else if (road == turn111 && cpChoose) begin
                    nextState = stStraight;
                end
            end
            stLeft: begin
                if (road == turn101) begin
                    nextState  = stStop;
                    nextResume = stRight;
                end else if (road == turn111 && cpLeft) begin
                    nextState  = stStop;
                    nextResume = stStraight;
                end
            end
            stRight: begin
                if (road == turn101 && rightConfirmed) begin
                    nextState = stError;
                end else if (road == turn111 && cpRight && rightConfirmed) begin
                    nextState  = stStop;
                    nextResume = stStraight;
                end
            end
            // Without a turn record, backing up always resumes to the left
            stBack: begin
                if (road == turn111) begin
                    nextState  = stStop;
                    nextResume = stLeft;
                end
            end
            stStop: if (timers.pauseDone) nextState = resume;
            stError: if (!run) nextState = stIdle;
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= stIdle;
            resume <= stIdle;
        end else begin
            state  <= run ? nextState : stIdle;
            resume <= nextResume;
        end
    end

    // Right turn confirmed after three turn111 samples in a row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rightCount     <= 2'd0;
            rightConfirmed <= 1'b0;
        end else if (state != stRight) begin
            rightCount     <= 2'd0;
            rightConfirmed <= 1'b0;
        end else if (road == turn111) begin
            if (rightCount == 2'd2) begin
                rightConfirmed <= 1'b1;
            end else begin
                rightCount <= rightCount + 2'd1;
            end
        end else begin
            rightCount <= 2'd0;
        end
    end

    // A checkpoint arms once its state has left the junction marker
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpStraight   <= 1'b0;
            cpChoose     <= 1'b0;
            cpLeft       <= 1'b0;
            cpRight      <= 1'b0;
            straightSeen <= 1'b0;
        end else begin
            if (!straightSeen || (inStraight && road != turn111)) begin
                cpStraight <= 1'b1;
            end else if (!inStraight) begin
                cpStraight <= 1'b0;
            end
            cpChoose <= (state == stChoose) && (cpChoose || road != turn111);
            cpLeft   <= (state == stLeft) && (cpLeft || road != turn111);
            cpRight  <= (state == stRight) && (cpRight || road != turn111);
            if (state == stStraight) straightSeen <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/statusLeds.sv */
`timescale 1ns/1ps
`default_nettype none

module statusLeds #(
    parameter int lampCycles = 30_000_000
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                carPkg::carState state,
    input  wire                carPkg::roadPattern road,
    input  wire                carPkg::timerStatus timers,
    output logic [15:0]        led
);
    import carPkg::*;

    localparam int LampW = $clog2(lampCycles + 1);

    logic [LampW-1:0] lampCount;
    logic [2:0]       lamp;
    logic [4:0]       code;
    logic [5:0]       activity;

    // Rotating lamp while waiting at the choice junction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCount <= '0;
            lamp      <= 3'b001;
        end else if (state != stChoose) begin
            lampCount <= '0;
            lamp      <= 3'b001;
        end else if (lampCount == LampW'(lampCycles - 1)) begin
            lampCount <= '0;
            lamp      <= {lamp[1:0], lamp[2]};
        end else begin
            lampCount <= lampCount + 1'b1;
        end
    end

    always_comb begin
        case (state)
            stStart: code = 5'b00001;
            stCount: code = 5'b00010;
            stStraight, stLittleLeft, stLittleRight: code = 5'b01000;
            stChoose: code = {lamp, 2'b00};
            stLeft: code = 5'b10000;
            stRight: code = 5'b00100;
            stStop: code = 5'b11100;
            stBack: code = 5'b01010;
            stError: code = 5'b11111;
            default: code = 5'b00000;
        endcase
    end

    always_comb begin
        case (state)
            stCount, stBack: activity = timers.blink ? 6'b000000 : 6'b111111;
            stStraight: activity = 6'b001100;
            stRight: activity = 6'b000011;
            stLeft: activity = 6'b110000;
            stStop: activity = 6'b111111;
            default: activity = 6'b000000;
        endcase
    end

    assign led = {code, 1'b0, activity, 1'b0, road};

endmodule

`default_nettype wire

/* logic/trackSensor.sv */
`timescale 1ns/1ps
`default_nettype none

module trackSensor (
    input  wire                clk,
    input  wire                rst,
    input  wire                leftTrack,
    input  wire                midTrack,
    input  wire                rightTrack,
    output carPkg::roadPattern road
);
    import carPkg::*;

    logic [2:0] syncA;
    logic [2:0] syncB;

    // Two-flop synchronizer on the raw sensor lines
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncA <= 3'b000;
            syncB <= 3'b000;
        end else begin
            syncA <= {leftTrack, midTrack, rightTrack};
            syncB <= syncA;
        end
    end

    assign road = roadPattern'(syncB);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the line car testbench with Verilator and runs it

if ! cd "$(dirname "$0")"; then
    echo "Cannot enter the project directory"
    exit 1
fi

if ! verilator --binary --timing -Wno-fatal -f files.f --top-module lineCarTb -o lineCarSim; then
    echo "Build failed"
    exit 1
fi

./obj_dir/lineCarSim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation PASSED"
exit 0

/* verif/lineCarTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lineCarTb;

    localparam int phaseCycles = 8;
    localparam int pauseCycles = 10;
    localparam int blinkCycles = 4;
    localparam int lampCycles  = 5;
    localparam int scanCycles  = 2;
    localparam int pwmPeriod   = 8;
    localparam int slowDuty    = 4;

    logic        clk;
    logic        rst;
    logic        run;
    logic        leftTrack;
    logic        midTrack;
    logic        rightTrack;
    logic [15:0] led;
    logic [3:0]  digit;
    logic [6:0]  segments;
    logic        in1;
    logic        in2;
    logic        in3;
    logic        in4;
    logic        pwmLeft;
    logic        pwmRight;
    logic [5:0]  motors;
    integer      seed;
    string       testName;

    lineCar #(
        .phaseCycles(phaseCycles), .pauseCycles(pauseCycles), .blinkCycles(blinkCycles),
        .lampCycles(lampCycles), .scanCycles(scanCycles), .pwmPeriod(pwmPeriod),
        .slowDuty(slowDuty)
    ) u_lineCar (
        .clk(clk), .rst(rst), .run(run), .leftTrack(leftTrack), .midTrack(midTrack),
        .rightTrack(rightTrack), .led(led), .digit(digit), .segments(segments),
        .in1(in1), .in2(in2), .in3(in3), .in4(in4), .pwmLeft(pwmLeft), .pwmRight(pwmRight)
    );

    assign motors = {in1, in2, in3, in4, pwmLeft, pwmRight};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Seven-segment patterns {g..a}, active low
    function automatic logic [6:0] glyphPattern(input int glyph);
        case (glyph)
            0: return 7'b1000000;
            1: return 7'b1111001;
            2: return 7'b0100100;
            3: return 7'b0110000;
            10: return 7'b0111111;
            12: return 7'b1001111;
            14: return 7'b1000111;
            default: return 7'b1111111;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s, %s: expected %0h, actual %0h", testName, name, expected,
                     actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("Error: %s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic setRoad(input logic [2:0] pattern);
        @(negedge clk);
        {leftTrack, midTrack, rightTrack} = pattern;
    endtask

    task automatic stepCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic waitLedState(input logic [4:0] code, input int timeout, input string what);
        int cycles;
        cycles = 0;
        while (led[15:11] !== code) begin
            if (cycles >= timeout) begin
                abortRun({"the ", what, " state never came"});
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic waitRoad(input logic [2:0] pattern, input int timeout);
        int cycles;
        cycles = 0;
        while (led[2:0] !== pattern) begin
            if (cycles >= timeout) begin
                abortRun($sformatf("road pattern %b never reached the LEDs", pattern));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic waitActivity(input logic [5:0] value, input int timeout, input string what);
        int cycles;
        cycles = 0;
        while (led[9:4] !== value) begin
            if (cycles >= timeout) begin
                abortRun({"the activity field never showed ", what});
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic readDigit(input int index, output logic [6:0] segs);
        int         cycles;
        logic [3:0] select;
        cycles = 0;
        // Only the selected digit line is pulled low
        select = 4'b1111;
        select[index] = 1'b0;
        @(negedge clk);
        while (digit !== select) begin
            if (cycles >= 4 * scanCycles + 2) begin
                abortRun($sformatf("digit %0d was never selected", index));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        segs = segments;
    endtask

    // Polls one digit until it shows the glyph
    task automatic waitDigitGlyph(input int index, input int glyph, input int reads,
                                  input string what);
        logic [6:0] segs;
        int         count;
        count = 0;
        readDigit(index, segs);
        while (segs !== glyphPattern(glyph)) begin
            if (count >= reads) begin
                abortRun({"the display never showed the ", what});
            end else begin
                readDigit(index, segs);
                count++;
            end
        end
    endtask

    task automatic measurePwm(output int leftHigh, output int rightHigh);
        leftHigh = 0;
        rightHigh = 0;
        repeat (pwmPeriod) begin
            @(negedge clk);
            leftHigh += int'(pwmLeft);
            rightHigh += int'(pwmRight);
        end
    endtask

    task automatic raiseRun();
        @(negedge clk);
        run = 1'b1;
        waitLedState(5'b00001, 4, "start");
    endtask

    // Idle is due on the edge right after run drops
    task automatic dropRun(input string what);
        @(negedge clk);
        run = 1'b0;
        @(negedge clk);
        check({what, " idle code"}, 32'(5'b00000), 32'(led[15:11]));
        check({what, " motors off"}, 32'(6'b000000), 32'(motors));
    endtask

    task automatic resetIdleTest();
        logic [6:0] segs;
        testName = "reset and idle";
        check("reset led field", 32'(12'h000), 32'(led[15:4]));
        check("reset motors", 32'(6'b000000), 32'(motors));
        readDigit(3, segs);
        check("idle digit 3", 32'(glyphPattern(1)), 32'(segs));
        readDigit(0, segs);
        check("idle digit 0", 32'(glyphPattern(14)), 32'(segs));
        // Every step changes the pattern, ending back on 000
        for (int p = 1; p <= 8; p++) begin
            setRoad(3'(p));
            waitRoad(3'(p), 3);
        end
    endtask

    task automatic startCountTest();
        logic [6:0] segs;
        testName = "start and countdown";
        raiseRun();
        setRoad(3'b010);
        waitLedState(5'b00010, 6, "count");
        for (int n = 3; n >= 0; n--) begin
            waitDigitGlyph(0, n, 6, $sformatf("countdown value %0d", n));
        end
        waitLedState(5'b01000, 4 * phaseCycles + 4, "straight");
        check("straight motors", 32'(6'b101011), 32'(motors));
        readDigit(3, segs);
        check("straight digit 3", 32'(glyphPattern(10)), 32'(segs));
        readDigit(2, segs);
        check("straight digit 2", 32'(glyphPattern(2)), 32'(segs));
    endtask

    task automatic lineKeepingTest();
        logic [2:0] pattern;
        int         pick;
        int         leftHigh;
        int         rightHigh;
        testName = "line keeping";
        for (int i = 0; i < 8; i++) begin
            pick = $unsigned($random(seed)) % 3;
            case (pick)
                0: pattern = 3'b001;
                1: pattern = 3'b100;
                default: pattern = 3'b010;
            endcase
            setRoad(pattern);
            // Two sync stages plus the state register
            stepCycles(3);
            check("line keeping road", 32'(pattern), 32'(led[2:0]));
            check("line keeping code", 32'(5'b01000), 32'(led[15:11]));
            check("line keeping activity", (pattern == 3'b010) ? 32'(6'b001100) : 32'd0,
                  32'(led[9:4]));
            check("line keeping direction", 32'(4'b1010), 32'({in1, in2, in3, in4}));
            measurePwm(leftHigh, rightHigh);
            check("line keeping left pwm", (pattern == 3'b100) ? slowDuty : pwmPeriod,
                  leftHigh);
            check("line keeping right pwm", (pattern == 3'b001) ? slowDuty : pwmPeriod,
                  rightHigh);
        end
    endtask

    task automatic lostLineTest();
        testName = "lost line and recovery";
        setRoad(3'b000);
        waitLedState(5'b11100, 6, "stop after lost line");
        check("stop motors", 32'(6'b000000), 32'(motors));
        waitLedState(5'b01010, pauseCycles + 4, "back");
        check("back motors", 32'(6'b010111), 32'(motors));
        waitActivity(6'b111111, 2, "the first back blink");
        waitActivity(6'b000000, blinkCycles + 2, "the back blink off");
        waitActivity(6'b111111, blinkCycles + 2, "the back blink on");
        setRoad(3'b111);
        waitLedState(5'b11100, 6, "stop after back");
        waitLedState(5'b10000, pauseCycles + 4, "left after back");
        check("left wheel bits", 32'(2'b01), 32'({in1, in2}));
        check("left right wheel", 32'(4'b1011), 32'({in3, in4, pwmLeft, pwmRight}));
    endtask

    task automatic choosePathTest();
        logic [6:0] segs;
        int         leftHigh;
        int         rightHigh;
        testName = "choose path";
        // Leave the left turn over its junction to get back to straight
        setRoad(3'b010);
        waitDigitGlyph(0, 1, 4, "left checkpoint");
        setRoad(3'b111);
        waitLedState(5'b11100, 6, "stop after left");
        waitLedState(5'b01000, pauseCycles + 4, "straight after left");
        setRoad(3'b010);
        waitDigitGlyph(0, 1, 4, "straight checkpoint");
        setRoad(3'b111);
        waitLedState(5'b00100, 6, "choose");
        waitLedState(5'b01000, lampCycles + 2, "second choose lamp");
        waitLedState(5'b10000, lampCycles + 2, "third choose lamp");
        waitLedState(5'b00100, lampCycles + 2, "wrapped choose lamp");
        check("choose direction", 32'(4'b1010), 32'({in1, in2, in3, in4}));
        measurePwm(leftHigh, rightHigh);
        check("choose left pwm", slowDuty, leftHigh);
        check("choose right pwm", slowDuty, rightHigh);
        readDigit(2, segs);
        check("choose digit 2", 32'(glyphPattern(1)), 32'(segs));
        setRoad(3'b101);
        waitLedState(5'b11100, 6, "stop after choose");
        waitLedState(5'b10000, pauseCycles + 4, "left after choose");
        check("left after choose direction", 32'(4'b0110), 32'({in1, in2, in3, in4}));
    endtask

    task automatic runSwitchTest();
        testName = "run switch";
        dropRun("from left");
        raiseRun();
        dropRun("from start");
        raiseRun();
        setRoad(3'b010);
        waitLedState(5'b00010, 6, "count before run drop");
        dropRun("from count");
    endtask

    initial begin
        seed = 32'h06c6_e967;
        testName = "reset";
        rst = 1'b1;
        run = 1'b0;
        leftTrack = 1'b0;
        midTrack = 1'b0;
        rightTrack = 1'b0;
        repeat (5) @(negedge clk);
        check("reset digit select", 32'(4'b1110), 32'(digit));
        rst = 1'b0;
        @(negedge clk);
        resetIdleTest();
        startCountTest();
        lineKeepingTest();
        lostLineTest();
        choosePathTest();
        runSwitchTest();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
